// File: all.f
source/alu_pkg.sv
source/isa_pkg.sv
source/reg_file.sv
source/pipe_stage_reg.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_stage.sv
source/pipe_core.sv
bench/pipe_core_assert.sv
bench/pipe_core_tb.sv

// File: bench/pipe_core_assert.sv
module pipe_core_assert #(
    parameter int width = 32
) (
    input logic             clk,
    input logic             rst,
    input logic             en,
    input logic             clear,
    input logic [width-1:0] q
);

    int fail_count = 0;

    reset_clears: assert property (@(posedge clk) rst && en |=> q == '0)
        else begin
            fail_count++;
            $error("Stage register not zero after reset");
        end

    hold_when_disabled: assert property (@(posedge clk) !en |=> $stable(q))
        else begin
            fail_count++;
            $error("Stage register changed while disabled");
        end

    clear_makes_bubble: assert property (@(posedge clk) clear && en |=> q == '0)
        else begin
            fail_count++;
            $error("Stage register not zero after clear");
        end

endmodule

bind pipe_stage_reg pipe_core_assert #(.width($bits(q))) stage_checks (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .clear (clear),
    .q     (q)
);

// File: bench/pipe_core_cases.txt
# cpu_en stall instr pc, then expected wb_en wb_addr wb_data mem_we mem_addr mem_wdata
# branch_taken branch_target; outputs show the instruction from two lines earlier
1 0 24011234 00000100 0 00 00000000 0 00000000 00000000 0 00000000
1 0 2402fffc 00000104 0 00 00000000 0 00000000 00000000 0 00000000
1 1 24070055 00000108 1 01 00001234 0 00001234 00000000 0 00000000
1 0 00221821 0000010c 1 02 fffffffc 0 fffffffc 00000000 0 00000000
1 0 34048000 00000110 0 00 00000000 0 00000000 00000000 0 00000000
1 0 00013900 00000114 1 03 00001230 0 00001230 fffffffc 0 00000000
1 0 00642823 00000118 1 04 00008000 0 00008000 00000000 0 00000000
1 0 00044202 0000011c 1 07 00012340 0 00012340 00001234 0 00000000
1 1 00000000 00000120 1 05 ffff9230 0 ffff9230 00008000 0 00000000
1 0 00a1302a 00000124 1 08 00000080 0 00000080 00008000 0 00000000
1 0 24200005 00000128 0 00 00000000 0 00000000 00000000 0 00000000
1 0 00e04826 0000012c 1 06 00000001 0 00000001 00001234 0 00000000
1 0 00e35024 00000130 0 00 00001239 0 00001239 00000000 0 00000000
1 0 3c0babcd 00000134 1 09 00012340 0 00012340 00000000 0 00000000
1 0 14610003 00000138 1 0a 00000200 0 00000200 00001230 0 00000000
1 0 1061fffe 0000013c 1 0b abcd0000 0 abcd0000 00000000 0 00000000
1 0 1127fffc 00000140 0 00 00002464 0 00002464 00001234 1 00000148
1 0 0c000400 00000144 0 00 00002464 0 00002464 00001234 0 00000138
1 0 ac650008 00000148 0 00 00024680 0 00024680 00012340 1 00000134
0 0 24070055 0000014c 1 1f 0000014c 0 00000000 00000000 1 00001000
0 0 24070055 0000014c 1 1f 0000014c 0 00000000 00000000 1 00001000
1 0 00000000 00000150 1 1f 0000014c 0 00000000 00000000 1 00001000
1 0 03e06025 00000154 0 00 00001238 1 00001238 ffff9230 0 00000000
1 0 00000000 00000158 0 00 00000000 0 00000000 00000000 0 00000000
1 0 00000000 0000015c 1 0c 0000014c 0 0000014c 00000000 0 00000000

// File: bench/pipe_core_tb.sv
module pipe_core_tb import isa_pkg::*; ();

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;
    localparam int reset_limit  = 64;
    localparam int line_limit   = 200;

    logic      clk;
    logic      rst;
    logic      cpu_en;
    logic      stall;
    word_t     instr;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      branch_taken;
    word_t     branch_target;

    int pass_count;
    int fail_count;
    int line_errors;

    pipe_core #(
        .data_width (32),
        .reg_count  (32)
    ) pipe_core_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_en        (cpu_en),
        .stall         (stall),
        .instr         (instr),
        .pc            (pc),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %08h, expected %08h", name, got, exp);
            line_errors++;
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %02h, expected %02h", name, got, exp);
            line_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
            line_errors++;
        end
    endtask

    initial begin : run_cases
        int        fd;
        int        fields;
        int        lines_read;
        int        wait_cycles;
        int        case_no;
        int        assert_fails;
        logic      timed_out;
        string     text;
        logic      en_v;
        logic      stall_v;
        word_t     instr_v;
        word_t     pc_v;
        logic      exp_wb_en;
        reg_addr_t exp_wb_addr;
        word_t     exp_wb_data;
        logic      exp_mem_we;
        word_t     exp_mem_addr;
        word_t     exp_mem_wdata;
        logic      exp_taken;
        word_t     exp_target;

        cpu_en     = 1'b1;
        stall      = 1'b0;
        instr      = '0;
        pc         = '0;
        pass_count = 0;
        fail_count = 0;
        lines_read = 0;
        case_no    = 0;
        timed_out  = 1'b0;
        fd         = 0;

        wait_cycles = 0;
        while (rst !== 1'b0 && wait_cycles < reset_limit) begin
            @(posedge clk);
            wait_cycles++;
        end
        @(negedge clk);
        if (rst !== 1'b0) begin
            $display("Reset was still high after %0d cycles", reset_limit);
            fail_count++;
        end else begin
            fd = $fopen("bench/pipe_core_cases.txt", "r");
            if (fd == 0) begin
                $display("Cannot open bench/pipe_core_cases.txt");
                fail_count++;
            end
        end

        while (fd != 0 && !$feof(fd) && !timed_out) begin
            text = "";
            fields = $fgets(text, fd);
            lines_read++;
            if (lines_read > line_limit) begin
                timed_out = 1'b1;
            end else if (text.len() > 1 && text.getc(0) != "#") begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                 en_v, stall_v, instr_v, pc_v, exp_wb_en, exp_wb_addr,
                                 exp_wb_data, exp_mem_we, exp_mem_addr, exp_mem_wdata,
                                 exp_taken, exp_target);
                if (fields != 12) begin
                    $display("Case file line %0d is malformed, %0d fields read",
                             lines_read, fields);
                    fail_count++;
                end else begin
                    cpu_en = en_v;
                    stall  = stall_v;
                    instr  = instr_v;
                    pc     = pc_v;
                    #(half_period - 1);   // Just before the rising edge.
                    line_errors = 0;
                    check_bit("wb_en", wb_en, exp_wb_en);
                    check_addr("wb_addr", wb_addr, exp_wb_addr);
                    check_word("wb_data", wb_data, exp_wb_data);
                    check_bit("mem_we", mem_we, exp_mem_we);
                    check_word("mem_addr", mem_addr, exp_mem_addr);
                    check_word("mem_wdata", mem_wdata, exp_mem_wdata);
                    check_bit("branch_taken", branch_taken, exp_taken);
                    check_word("branch_target", branch_target, exp_target);
                    if (line_errors == 0) begin
                        pass_count++;
                        $display("case %0d pass", case_no);
                    end else begin
                        fail_count++;
                        $display("case %0d fail", case_no);
                    end
                    case_no++;
                    @(negedge clk);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (timed_out) begin
            $display("Case loop gave up after %0d lines", line_limit);
        end
        assert_fails = pipe_core_i.id_ex_reg.stage_checks.fail_count
                     + pipe_core_i.ex_wb_reg.stage_checks.fail_count;
        if (assert_fails != 0) begin
            $display("Stage register assertions failed %0d times", assert_fails);
        end
        $display("Cases passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && assert_fails == 0 && !timed_out && case_no > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module pipe_core_tb -f all.f
output=$(./obj_dir/Vpipe_core_tb +verilator+error+limit+1000)
echo "$output"
if echo "$output" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1

// File: source/alu_execute.sv
module alu_execute import isa_pkg::*, alu_pkg::*; (
    input  id_ex_t id_ex,
    output ex_wb_t ex_wb
);

    word_t opa;
    word_t opb;
    word_t result;
    logic  regs_equal;
    logic  taken;

    assign opa = (id_ex.use_shamt == opa_shamt) ? {27'd0, id_ex.shamt} : id_ex.op_a;
    assign opb = (id_ex.use_imm == opb_imm) ? id_ex.imm : id_ex.op_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: result = opa + opb;
            alu_sub: result = opa - opb;
            alu_and: result = opa & opb;
            alu_or:  result = opa | opb;
            alu_xor: result = opa ^ opb;
            alu_slt: result = {31'd0, $signed(opa) < $signed(opb)};
            alu_sll: result = opb << opa[4:0];   // Shift rt by shamt.
            alu_srl: result = opb >> opa[4:0];
            alu_lui: result = {opb[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // Branches compare the raw register operands, never the immediate.
    assign regs_equal = (id_ex.op_a == id_ex.op_b);
    assign taken      = id_ex.is_jump || (id_ex.is_branch && (regs_equal ^ id_ex.branch_ne));

    always_comb begin
        ex_wb              = '0;
        ex_wb.alu_result   = result;
        ex_wb.waddr        = id_ex.waddr;
        ex_wb.reg_write    = id_ex.reg_write;
        ex_wb.is_link      = id_ex.is_link;
        ex_wb.pc_plus8     = id_ex.pc_plus8;
        ex_wb.mem_write    = id_ex.mem_write;
        ex_wb.store_data   = id_ex.store_data;
        ex_wb.branch_taken = taken;
        ex_wb.target       = id_ex.target;
    end

endmodule

// File: source/alu_pkg.sv
package alu_pkg;

    // ALU operations.
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,   // Signed compare.
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_lui = 4'd8    // Immediate into the upper half.
    } alu_op_t;

    // Operand A source. Shifts take the shamt field.
    typedef enum logic {
        opa_reg   = 1'b0,
        opa_shamt = 1'b1
    } opa_sel_t;

    // Operand B source.
    typedef enum logic {
        opb_reg = 1'b0,
        opb_imm = 1'b1
    } opb_sel_t;

endpackage

// File: source/instr_decode.sv
module instr_decode import isa_pkg::*, alu_pkg::*; (
    input  word_t     instr,
    input  word_t     pc,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output id_ex_t    id_ex
);

    opcode_t opcode;
    funct_t  funct;
    logic    legal;
    word_t   imm_sext;
    word_t   imm_zext;
    word_t   pc_plus4;

    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        opcode = opcode_t'(instr[31:26]);
        funct  = funct_t'(instr[5:0]);
        legal  = 1'b1;
        id_ex  = '0;
        id_ex.op_a       = rs_data;
        id_ex.op_b       = rt_data;
        id_ex.shamt      = instr[10:6];
        id_ex.store_data = rt_data;
        id_ex.pc_plus8   = pc + 32'd8;
        case (opcode)
            op_special: begin
                id_ex.reg_write = 1'b1;
                id_ex.waddr     = instr[15:11];
                case (funct)
                    fn_addu: id_ex.alu_op = alu_add;
                    fn_subu: id_ex.alu_op = alu_sub;
                    fn_and:  id_ex.alu_op = alu_and;
                    fn_or:   id_ex.alu_op = alu_or;
                    fn_xor:  id_ex.alu_op = alu_xor;
                    fn_slt:  id_ex.alu_op = alu_slt;
                    fn_sll: begin
                        id_ex.alu_op    = alu_sll;
                        id_ex.use_shamt = opa_shamt;
                    end
                    fn_srl: begin
                        id_ex.alu_op    = alu_srl;
                        id_ex.use_shamt = opa_shamt;
                    end
                    default: legal = 1'b0;
                endcase
            end
            op_addiu, op_andi, op_ori, op_lui: begin
                id_ex.reg_write = 1'b1;
                id_ex.waddr     = rt_addr;
                id_ex.use_imm   = opb_imm;
                // Logical immediates are zero extended.
                id_ex.imm       = (opcode == op_addiu) ? imm_sext : imm_zext;
                case (opcode)
                    op_andi: id_ex.alu_op = alu_and;
                    op_ori:  id_ex.alu_op = alu_or;
                    op_lui:  id_ex.alu_op = alu_lui;
                    default: id_ex.alu_op = alu_add;
                endcase
            end
            op_beq, op_bne: begin
                id_ex.is_branch = 1'b1;
                id_ex.branch_ne = (opcode == op_bne);
                id_ex.target    = pc_plus4 + {imm_sext[29:0], 2'b00};
            end
            op_j, op_jal: begin
                id_ex.is_jump   = 1'b1;
                id_ex.target    = {pc_plus4[31:28], instr[25:0], 2'b00};
                id_ex.is_link   = (opcode == op_jal);
                id_ex.reg_write = (opcode == op_jal);
                id_ex.waddr     = (opcode == op_jal) ? 5'd31 : 5'd0; // Link register.
            end
            op_sw: begin
                id_ex.mem_write = 1'b1;
                id_ex.use_imm   = opb_imm;
                id_ex.imm       = imm_sext;
                id_ex.alu_op    = alu_add;   // Address is base plus offset.
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            id_ex = '0;   // Unsupported encodings become a bubble.
        end
    end

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

    import alu_pkg::*;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0] {
        op_special = 6'h00,   // R-type, decoded by funct.
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    // Decoded bundle held in the ID/EX register.
    typedef struct packed {
        word_t     op_a;          // rs value.
        word_t     op_b;          // rt value.
        logic [4:0] shamt;
        word_t     imm;           // Already extended.
        alu_op_t   alu_op;
        opa_sel_t  use_shamt;
        opb_sel_t  use_imm;
        reg_addr_t waddr;
        logic      reg_write;
        logic      mem_write;
        word_t     store_data;
        logic      is_branch;
        logic      branch_ne;     // Set for bne.
        logic      is_jump;
        logic      is_link;
        word_t     target;
        word_t     pc_plus8;
    } id_ex_t;

    // Execute result held in the EX/WB register.
    typedef struct packed {
        word_t     alu_result;
        reg_addr_t waddr;
        logic      reg_write;
        logic      is_link;
        word_t     pc_plus8;
        logic      mem_write;
        word_t     store_data;
        logic      branch_taken;
        word_t     target;
    } ex_wb_t;

endpackage

// File: source/pipe_core.sv
module pipe_core import isa_pkg::*; #(
    parameter int data_width = 32,
    parameter int reg_count  = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_en,
    input  logic      stall,
    input  word_t     instr,
    input  word_t     pc,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      branch_taken,
    output word_t     branch_target
);

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_wb_t    ex_wb_d;
    ex_wb_t    ex_wb_q;
    logic      rf_we;

    assign rf_we = wb_en && cpu_en;   // Commit freezes with the pipeline.

    instr_decode instr_decode_i (
        .instr   (instr),
        .pc      (pc),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .id_ex   (id_ex_d)
    );

    reg_file #(
        .data_width (data_width),
        .reg_count  (reg_count)
    ) reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (rf_we),
        .waddr   (wb_addr),
        .wdata   (wb_data)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk   (clk),
        .rst   (rst),
        .en    (cpu_en),
        .clear (stall),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    alu_execute alu_execute_i (
        .id_ex (id_ex_q),
        .ex_wb (ex_wb_d)
    );

    pipe_stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk   (clk),
        .rst   (rst),
        .en    (cpu_en),
        .clear (1'b0),   // Bubbles enter at ID/EX only.
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    result_stage result_stage_i (
        .ex_wb         (ex_wb_q),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// File: source/pipe_stage_reg.sv
module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // Enable has priority, so reset only takes effect while the core runs.
    always_ff @(posedge clk) begin
        if (en) begin
            if (rst || clear) begin
                q <= '0;   // Bubble.
            end else begin
                q <= d;
            end
        end
    end

endmodule

// File: source/reg_file.sv
module reg_file #(
    parameter int data_width = 32,
    parameter int reg_count  = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [$clog2(reg_count)-1:0] rs_addr,
    input  logic [$clog2(reg_count)-1:0] rt_addr,
    output logic [data_width-1:0]        rs_data,
    output logic [data_width-1:0]        rt_data,
    input  logic                         we,
    input  logic [$clog2(reg_count)-1:0] waddr,
    input  logic [data_width-1:0]        wdata
);

    logic [data_width-1:0] regs [reg_count];
    logic                  wr_live;

    assign wr_live = we && (waddr != '0);   // Register 0 stays zero.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a read in the commit cycle sees the new value.
    assign rs_data = (wr_live && waddr == rs_addr) ? wdata : regs[rs_addr];
    assign rt_data = (wr_live && waddr == rt_addr) ? wdata : regs[rt_addr];

endmodule

// File: source/result_stage.sv
module result_stage import isa_pkg::*; (
    input  ex_wb_t    ex_wb,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      branch_taken,
    output word_t     branch_target
);

    // No write strobe for the zero register.
    assign wb_en   = ex_wb.reg_write && (ex_wb.waddr != 5'd0);
    assign wb_addr = ex_wb.waddr;
    assign wb_data = ex_wb.is_link ? ex_wb.pc_plus8 : ex_wb.alu_result; // jal links pc+8.

    assign mem_we    = ex_wb.mem_write;
    assign mem_addr  = ex_wb.alu_result;   // Base plus offset.
    assign mem_wdata = ex_wb.store_data;

    assign branch_taken  = ex_wb.branch_taken;
    assign branch_target = ex_wb.target;

endmodule
